/* hdl/div_arith_pkg.sv */
// Divider arithmetic definitions
package div_arith_pkg;

   // Operand and result width
   localparam int DATA_W = 32;

   // Operation code, bit 0 selects unsigned, bit 1 selects remainder
   localparam int OP_W = 2;
   localparam logic [OP_W-1:0] OP_DIV  = 2'd0;
   localparam logic [OP_W-1:0] OP_DIVU = 2'd1;
   localparam logic [OP_W-1:0] OP_REM  = 2'd2;
   localparam logic [OP_W-1:0] OP_REMU = 2'd3;

   localparam int OP_UNSIGNED_BIT = 0;
   localparam int OP_REM_BIT      = 1;

   // One quotient bit per iteration, then one correction step
   localparam int ITER_COUNT    = 32;
   localparam int CORRECT_CYCLE = 33;
   localparam int CNT_W         = 6;

endpackage

/* hdl/div_flow_pkg.sv */
// Divider result flow definitions
package div_flow_pkg;

   // Result queue
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = 2;

   // Output channel credits held after reset
   localparam int OUT_CREDITS = 2;
   localparam int CRED_W      = 2;

endpackage

/* hdl/div_push_if.sv */
// Core to result queue channel
`timescale 1ns/100ps

interface div_push_if
   import div_arith_pkg::*;
();

   // Finished result, always lands in a reserved slot
   logic              push;
   logic [DATA_W-1:0] quot;
   logic [DATA_W-1:0] rem;
   logic              is_rem;
   logic              neg_q;
   logic              neg_r;

   // Slot reservation
   logic              reserve;
   logic              release_slot;
   logic              slot_free;

   modport core (
      output push, quot, rem, is_rem, neg_q, neg_r, reserve, release_slot,
      input  slot_free
   );

   modport queue (
      input  push, quot, rem, is_rem, neg_q, neg_r, reserve, release_slot,
      output slot_free
   );

endinterface

/* hdl/div_pop_if.sv */
// Result queue to sender channel
`timescale 1ns/100ps

interface div_pop_if
   import div_arith_pkg::*;
();

   // Head entry of the queue
   logic              valid;
   logic [DATA_W-1:0] quot;
   logic [DATA_W-1:0] rem;
   logic              is_rem;
   logic              neg_q;
   logic              neg_r;

   // Only while valid is high
   logic              pop;

   modport queue (
      output valid, quot, rem, is_rem, neg_q, neg_r,
      input  pop
   );

   modport send (
      input  valid, quot, rem, is_rem, neg_q, neg_r,
      output pop
   );

endinterface

/* hdl/div_iterate.sv */
// Iterative divide core
`timescale 1ns/100ps

module div_iterate
   import div_arith_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req_valid,
   output logic              req_ready,
   input  logic [OP_W-1:0]   req_op,
   input  logic [DATA_W-1:0] req_dividend,
   input  logic [DATA_W-1:0] req_divisor,
   input  logic              cancel,
   div_push_if.core          push_if
);

   logic              busy;
   logic [CNT_W-1:0]  count;
   logic              accept;
   logic              iter_step;
   logic              correct_step;
   logic              push_cycle;

   logic              sign_in;
   logic              dvd_neg;
   logic              dvs_neg;
   logic [DATA_W-1:0] dvd_mag;
   logic [DATA_W-1:0] dvs_mag;

   // Partial remainder carries one extra sign bit
   logic [DATA_W:0]   a_ff;
   logic [DATA_W:0]   m_ff;
   logic [DATA_W-1:0] q_ff;
   logic [DATA_W:0]   a_shift;
   logic [DATA_W:0]   a_sum;
   logic              rem_ff;
   logic              neg_q_ff;
   logic              neg_r_ff;

   assign req_ready = ~busy & push_if.slot_free;
   assign accept    = req_valid & req_ready;

   // Signed divide by zero is run as unsigned so the raw dividend comes back
   assign sign_in = ~req_op[OP_UNSIGNED_BIT] & (req_divisor != '0);
   assign dvd_neg = sign_in & req_dividend[DATA_W-1];
   assign dvs_neg = sign_in & req_divisor[DATA_W-1];
   assign dvd_mag = dvd_neg ? -req_dividend : req_dividend;
   assign dvs_mag = dvs_neg ? -req_divisor : req_divisor;

   // Count runs 1..32 for quotient bits, 33 to correct, 34 to push
   assign iter_step    = busy & (count <= CNT_W'(ITER_COUNT));
   assign correct_step = busy & (count == CNT_W'(CORRECT_CYCLE));
   assign push_cycle   = busy & (count == CNT_W'(CORRECT_CYCLE + 1));

   // Non-restoring step, add back when the last remainder went negative
   assign a_shift = {a_ff[DATA_W-1:0], q_ff[DATA_W-1]};
   assign a_sum   = a_ff[DATA_W] ? (a_shift + m_ff) : (a_shift - m_ff);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         count <= '0;
      end else if (accept) begin
         busy  <= 1'b1;
         count <= CNT_W'(1);
      end else if (busy) begin
         if (cancel || push_cycle) begin
            busy  <= 1'b0;
            count <= '0;
         end else begin
            count <= count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         a_ff     <= '0;
         q_ff     <= dvd_mag;
         m_ff     <= {1'b0, dvs_mag};
         rem_ff   <= req_op[OP_REM_BIT];
         neg_q_ff <= dvd_neg ^ dvs_neg;
         neg_r_ff <= dvd_neg;
      end else if (iter_step) begin
         a_ff <= a_sum;
         q_ff <= {q_ff[DATA_W-2:0], ~a_sum[DATA_W]};
      end else if (correct_step && a_ff[DATA_W]) begin
         // Restore a negative final remainder
         a_ff <= a_ff + m_ff;
      end
   end

   assign push_if.reserve      = accept;
   assign push_if.release_slot = busy & cancel;
   assign push_if.push         = push_cycle & ~cancel;
   assign push_if.quot         = q_ff;
   assign push_if.rem          = a_ff[DATA_W-1:0];
   assign push_if.is_rem       = rem_ff;
   assign push_if.neg_q        = neg_q_ff;
   assign push_if.neg_r        = neg_r_ff;

endmodule

/* hdl/div_result_queue.sv */
// Result FIFO with slot reservation
`timescale 1ns/100ps

module div_result_queue
   import div_arith_pkg::*;
   import div_flow_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   div_push_if.queue push_if,
   div_pop_if.queue  pop_if
);

   logic [DATA_W-1:0] quot_mem [QUEUE_DEPTH];
   logic [DATA_W-1:0] rem_mem  [QUEUE_DEPTH];
   logic [2:0]        flag_mem [QUEUE_DEPTH];

   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   // Entries written and not yet popped
   logic [QPTR_W:0]   stored;
   // Stored entries plus slots held by the core
   logic [QPTR_W:0]   used;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         stored <= '0;
         used   <= '0;
      end else begin
         if (push_if.push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_if.pop)
            rd_ptr <= rd_ptr + 1'b1;
         stored <= stored + (QPTR_W+1)'(push_if.push) - (QPTR_W+1)'(pop_if.pop);
         used   <= used + (QPTR_W+1)'(push_if.reserve)
                        - (QPTR_W+1)'(push_if.release_slot)
                        - (QPTR_W+1)'(pop_if.pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push_if.push) begin
         quot_mem[wr_ptr] <= push_if.quot;
         rem_mem[wr_ptr]  <= push_if.rem;
         flag_mem[wr_ptr] <= {push_if.is_rem, push_if.neg_q, push_if.neg_r};
      end
   end

   assign push_if.slot_free = (used < QUEUE_DEPTH);

   // Head entry
   assign pop_if.valid  = (stored != '0);
   assign pop_if.quot   = quot_mem[rd_ptr];
   assign pop_if.rem    = rem_mem[rd_ptr];
   assign pop_if.is_rem = flag_mem[rd_ptr][2];
   assign pop_if.neg_q  = flag_mem[rd_ptr][1];
   assign pop_if.neg_r  = flag_mem[rd_ptr][0];

endmodule

/* hdl/div_result_send.sv */
// Credit-counted result sender
`timescale 1ns/100ps

module div_result_send
   import div_arith_pkg::*;
   import div_flow_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   div_pop_if.send           pop_if,
   output logic              res_valid,
   output logic [DATA_W-1:0] res_data,
   input  logic              res_credit
);

   logic [CRED_W-1:0] credits;
   logic              send;
   logic [DATA_W-1:0] sel_mag;
   logic              sel_neg;
   logic [DATA_W-1:0] result;

   // One result per held credit
   assign send       = pop_if.valid & (credits != '0);
   assign pop_if.pop = send;

   // Pick quotient or remainder, then restore its sign
   assign sel_mag = pop_if.is_rem ? pop_if.rem : pop_if.quot;
   assign sel_neg = pop_if.is_rem ? pop_if.neg_r : pop_if.neg_q;
   assign result  = sel_neg ? -sel_mag : sel_mag;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits   <= CRED_W'(OUT_CREDITS);
         res_valid <= 1'b0;
      end else begin
         credits   <= credits - CRED_W'(send) + CRED_W'(res_credit);
         res_valid <= send;
      end
   end

   always_ff @(posedge clk) begin
      if (send)
         res_data <= result;
   end

endmodule

/* hdl/div_unit.sv */
// Integer divide unit top
`timescale 1ns/100ps

module div_unit
   import div_arith_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,

   // Request
   input  logic              req_valid,
   output logic              req_ready,
   input  logic [OP_W-1:0]   req_op,
   input  logic [DATA_W-1:0] req_dividend,
   input  logic [DATA_W-1:0] req_divisor,

   // Drops the operation being iterated
   input  logic              cancel,

   // Credit based result channel
   output logic              res_valid,
   output logic [DATA_W-1:0] res_data,
   input  logic              res_credit
);

   div_push_if push_bus ();
   div_pop_if  pop_bus ();

   div_iterate u_iterate (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_op       (req_op),
      .req_dividend (req_dividend),
      .req_divisor  (req_divisor),
      .cancel       (cancel),
      .push_if      (push_bus.core)
   );

   div_result_queue u_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_if (push_bus.queue),
      .pop_if  (pop_bus.queue)
   );

   div_result_send u_send (
      .clk        (clk),
      .rst_n      (rst_n),
      .pop_if     (pop_bus.send),
      .res_valid  (res_valid),
      .res_data   (res_data),
      .res_credit (res_credit)
   );

endmodule

/* bench/div_checker.sv */
// Divide unit result checker
`timescale 1ns/100ps

module div_checker
   import div_arith_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              exp_push,
   input  logic [31:0]       exp_test,
   input  logic [DATA_W-1:0] exp_value,
   input  logic              res_valid,
   input  logic [DATA_W-1:0] res_data,
   output int                pass_count,
   output int                fail_count
);

   // Expected results in request order
   logic [DATA_W-1:0] value_q [$];
   logic [31:0]       test_q  [$];

   always @(posedge clk) begin
      logic [DATA_W-1:0] want;
      logic [31:0]       test_id;
      if (!rst_n) begin
         pass_count = 0;
         fail_count = 0;
         value_q.delete();
         test_q.delete();
      end else begin
         if (exp_push) begin
            value_q.push_back(exp_value);
            test_q.push_back(exp_test);
         end
         if (res_valid) begin
            if (value_q.size() == 0) begin
               $display("Result %h came out at %0t with no request waiting for it",
                        res_data, $time);
               fail_count++;
            end else begin
               want    = value_q.pop_front();
               test_id = test_q.pop_front();
               if (res_data === want) begin
                  $display("test %0d: pass, result %h", test_id, res_data);
                  pass_count++;
               end else begin
                  $display("Fail at %0t: test %0d expected %h, got %h",
                           $time, test_id, want, res_data);
                  fail_count++;
               end
            end
         end
      end
   end

endmodule

/* bench/div_unit_assert.sv */
// Divide unit flow assertions
`timescale 1ns/100ps

module div_unit_assert
   import div_flow_pkg::*;
(
   input logic              clk,
   input logic              rst_n,
   input logic              res_valid,
   input logic              res_credit,
   input logic              push,
   input logic [QPTR_W:0]   stored,
   input logic [QPTR_W:0]   used,
   input logic              pop,
   input logic              head_valid
);

   // Count of failed assertions
   int assert_fails = 0;

   // Credits the sender should hold, seen from the result channel
   int held;
   // Results pushed and not yet popped
   int queued;

   always @(posedge clk) begin
      if (!rst_n) begin
         held   <= OUT_CREDITS;
         queued <= 0;
      end else begin
         held   <= held - int'(res_valid) + int'(res_credit);
         queued <= queued + int'(push) - int'(pop);
      end
   end

   // A result leaves only while a credit is held
   credit_held: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (held != 0))
      else begin
         assert_fails++;
         $error("res_valid was raised while the sender held no credit");
      end

   // Every push lands in a slot reserved at acceptance
   push_reserved: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (used > stored))
      else begin
         assert_fails++;
         $error("push happened without a reserved queue slot");
      end

   pop_when_valid: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> (head_valid && queued != 0))
      else begin
         assert_fails++;
         $error("pop happened while the queue head was not valid");
      end

endmodule

bind div_unit div_unit_assert u_unit_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .res_valid  (res_valid),
   .res_credit (res_credit),
   .push       (push_bus.push),
   .stored     (u_queue.stored),
   .used       (u_queue.used),
   .pop        (pop_bus.pop),
   .head_valid (pop_bus.valid)
);

/* bench/tb_div_unit.sv */
// Divide unit testbench
`timescale 1ns/100ps

module tb_div_unit
   import div_arith_pkg::*;
();

   localparam int MAX_TESTS = 64;
   localparam int PAT_COLS  = 6;

   logic              clk;
   logic              rst_n;
   logic              req_valid;
   logic              req_ready;
   logic [OP_W-1:0]   req_op;
   logic [DATA_W-1:0] req_dividend;
   logic [DATA_W-1:0] req_divisor;
   logic              cancel;
   logic              res_valid;
   logic [DATA_W-1:0] res_data;
   logic              res_credit;

   logic              exp_push;
   logic [31:0]       exp_test;
   logic [DATA_W-1:0] exp_value;
   int                pass_count;
   int                fail_count;

   logic [31:0]       pat_mem [0:MAX_TESTS*PAT_COLS-1];
   int                num_tests;
   int                num_expected;
   int                cycle = 0;
   int                cycle_limit;
   int                seed = 32'hc569;
   // Cycle numbers at which a held credit goes back
   int                credit_due [$];

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   div_unit dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_op       (req_op),
      .req_dividend (req_dividend),
      .req_divisor  (req_divisor),
      .cancel       (cancel),
      .res_valid    (res_valid),
      .res_data     (res_data),
      .res_credit   (res_credit)
   );

   div_checker u_checker (
      .clk        (clk),
      .rst_n      (rst_n),
      .exp_push   (exp_push),
      .exp_test   (exp_test),
      .exp_value  (exp_value),
      .res_valid  (res_valid),
      .res_data   (res_data),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test FAILED");
         $finish;
      end
   end

   // Credits go back after a short random delay, now and then after a long one
   initial begin
      res_credit = 1'b0;
      forever begin
         @(negedge clk);
         res_credit = 1'b0;
         if (res_valid) begin
            if (($random(seed) & 7) == 0)
               credit_due.push_back(cycle + 60);
            else
               credit_due.push_back(cycle + ($random(seed) & 15));
         end
         if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
            res_credit = 1'b1;
            void'(credit_due.pop_front());
         end
      end
   end

   initial begin
      int t;
      int base;
      int delay;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_op       = '0;
      req_dividend = '0;
      req_divisor  = '0;
      cancel       = 1'b0;
      exp_push     = 1'b0;
      exp_test     = '0;
      exp_value    = '0;
      $readmemh("bench/div_patterns.txt", pat_mem);
      num_tests    = 0;
      num_expected = 0;
      while (num_tests < MAX_TESTS && pat_mem[num_tests*PAT_COLS] != 0) begin
         if (pat_mem[num_tests*PAT_COLS+4] == 0)
            num_expected++;
         num_tests++;
      end
      cycle_limit = 64 * num_tests + 200;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      for (t = 0; t < num_tests; t++) begin
         base = t * PAT_COLS;
         @(negedge clk);
         req_valid    = 1'b1;
         req_op       = pat_mem[base+1][OP_W-1:0];
         req_dividend = pat_mem[base+2];
         req_divisor  = pat_mem[base+3];
         while (!req_ready)
            @(negedge clk);
         // Next rising edge accepts it
         exp_push  = (pat_mem[base+4] == 0);
         exp_test  = pat_mem[base];
         exp_value = pat_mem[base+5];
         @(posedge clk);
         delay = 1 + ($unsigned($random(seed)) % 20);
         @(negedge clk);
         req_valid = 1'b0;
         exp_push  = 1'b0;
         if (pat_mem[base+4] != 0) begin
            repeat (delay - 1) @(negedge clk);
            cancel = 1'b1;
            @(negedge clk);
            cancel = 1'b0;
            $display("test %0d: cancelled %0d cycles after acceptance", pat_mem[base], delay);
         end
      end

      while (pass_count + fail_count < num_expected)
         @(negedge clk);
      // Quiet tail so a result that should have been dropped still shows up
      repeat (40) @(negedge clk);
      $display("Results: %0d passed, %0d failed, %0d assertion failures",
               pass_count, fail_count, dut.u_unit_assert.assert_fails);
      if (fail_count == 0 && dut.u_unit_assert.assert_fails == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

/* compile.f */
hdl/div_arith_pkg.sv
hdl/div_flow_pkg.sv
hdl/div_push_if.sv
hdl/div_pop_if.sv
hdl/div_iterate.sv
hdl/div_result_queue.sv
hdl/div_result_send.sv
hdl/div_unit.sv
bench/div_checker.sv
bench/div_unit_assert.sv
bench/tb_div_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the divide unit testbench with Verilator
rm -f sim.log \
   && verilator --binary --timing --assert --top-module tb_div_unit -f compile.f \
      -o sim_div_unit \
   && ./obj_dir/sim_div_unit | tee sim.log \
   && grep -q "^Test OK$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* bench/div_patterns.txt */
// Columns are test op dividend divisor cancel expected in hex
// Op 0 is DIV, 1 DIVU, 2 REM, 3 REMU and a line of zeros ends the list
01 1 00000064 00000007 0 0000000e
02 3 00000064 00000007 0 00000002
03 1 ffffffff 00000010 0 0fffffff
04 3 ffffffff 00000010 0 0000000f
05 1 80000000 00000003 0 2aaaaaaa
06 3 80000000 00000003 0 00000002
07 0 fffffff9 00000002 0 fffffffd
08 2 fffffff9 00000002 0 ffffffff
09 0 00000007 fffffffe 0 fffffffd
0a 2 00000007 fffffffe 0 00000001
0b 0 ffffff9c fffffff9 0 0000000e
0c 2 ffffff9c fffffff9 0 fffffffe
0d 0 000004d2 00000000 0 ffffffff
0e 2 000004d2 00000000 0 000004d2
0f 1 000004d2 00000000 0 ffffffff
10 3 80000000 00000000 0 80000000
11 0 fffffffb 00000000 0 ffffffff
12 2 fffffffb 00000000 0 fffffffb
13 0 80000000 ffffffff 0 80000000
14 2 80000000 ffffffff 0 00000000
15 1 12345678 00001000 1 00012345
16 0 00000064 0000000a 0 0000000a
17 3 deadbeef 00010000 1 0000beef
18 0 7fffffff 00000001 0 7fffffff
19 2 7fffffff 00000010 0 0000000f
1a 1 00000000 00000005 1 00000000
1b 0 80000000 00000002 0 c0000000
1c 2 80000000 00000007 0 fffffffe
00 0 00000000 00000000 0 00000000
